// File: hw/pe_pkg.sv
`default_nettype none

package pe_pkg;

    // one weight, one activation and one truncated product share this width
    localparam int WORD_W = 16;

    // column and row coordinates wrap modulo 32
    localparam int COORD_W = 5;

    // weights held in the bank, and activations carried by one beat
    localparam int LANES = 4;

    // every weight meets every activation of a beat
    localparam int PROD_LANES = LANES * LANES;

    // a weight beat uses only its low 26 bits
    typedef struct packed {
        logic [77:0]              pad;
        logic [COORD_W-1:0]       row;
        logic [COORD_W-1:0]       col;
        logic signed [WORD_W-1:0] weight;
    } weight_beat_t;

    // an activation beat fills the whole word, lane 0 low in each field
    typedef struct packed {
        logic [LANES-1:0][COORD_W-1:0]       rows;
        logic [LANES-1:0][COORD_W-1:0]       cols;
        logic signed [LANES-1:0][WORD_W-1:0] acts;
    } act_beat_t;

    // the same input word is read as either beat kind.
    // The phase of the controller decides which view is meaningful
    typedef union packed {
        weight_beat_t w;
        act_beat_t    a;
    } beat_u;

    // the element never goes back to idle once it leaves it
    typedef enum logic [1:0] {
        idle        = 2'd0,
        load_weight = 2'd1,
        load_image  = 2'd2
    } phase_t;

endpackage

`default_nettype wire

// File: hw/pe_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module pe_ctrl (
    input  wire         clk,
    input  wire         irst_n,
    input  wire         in_valid,
    input  wire  [15:0] pixels,
    output logic        weight_we,
    output logic [1:0]  weight_slot,
    output logic        act_fire
);

    import pe_pkg::*;

    phase_t      state;
    logic [1:0]  slot_cnt;
    logic [15:0] act_cnt;
    logic [15:0] act_cnt_inc;

    // the counters only move on accepted beats, so idle gaps are harmless
    assign act_cnt_inc = act_cnt + 16'd1;

    // weight beats arrive in idle and load_weight and always go to the slot counter
    assign weight_we   = in_valid && ((state == idle) || (state == load_weight));
    assign weight_slot = slot_cnt;

    // every valid beat seen in the image phase is an activation beat
    assign act_fire = in_valid && (state == load_image);

    always_ff @(posedge clk or negedge irst_n) begin
        if (!irst_n) begin
            state    <= idle;
            slot_cnt <= 2'd0;
            act_cnt  <= 16'd0;
        end else if (in_valid) begin
            case (state)
                idle: begin
                    // this first beat is slot 0, written in the same cycle
                    state    <= load_weight;
                    slot_cnt <= 2'd1;
                end
                load_weight: begin
                    // the slot counter wraps back to 0 after slot 3
                    slot_cnt <= slot_cnt + 2'd1;
                    if (slot_cnt == 2'd3) begin
                        state   <= load_image;
                        act_cnt <= 16'd0;
                    end
                end
                load_image: begin
                    // the last activation beat of an image hands back to weight loading
                    if (act_cnt_inc == pixels) begin
                        state    <= load_weight;
                        act_cnt  <= 16'd0;
                        slot_cnt <= 2'd0;
                    end else begin
                        act_cnt <= act_cnt_inc;
                    end
                end
                default: begin
                    state    <= idle;
                    slot_cnt <= 2'd0;
                    act_cnt  <= 16'd0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/weight_bank.sv
`timescale 1ns/1ps
`default_nettype none

module weight_bank (
    input  wire                                        clk,
    input  wire                                        irst_n,
    input  wire                                        weight_we,
    input  wire  [1:0]                                 weight_slot,
    input  pe_pkg::weight_beat_t                       wbeat,
    output logic [pe_pkg::LANES*pe_pkg::WORD_W-1:0]    weights,
    output logic [pe_pkg::LANES*pe_pkg::COORD_W-1:0]   w_cols,
    output logic [pe_pkg::LANES*pe_pkg::COORD_W-1:0]   w_rows
);

    import pe_pkg::*;

    // one weight, column and row triple per slot, slot 0 in the low bits
    logic [LANES-1:0][WORD_W-1:0]  weight_q;
    logic [LANES-1:0][COORD_W-1:0] col_q;
    logic [LANES-1:0][COORD_W-1:0] row_q;

    always_ff @(posedge clk or negedge irst_n) begin
        if (!irst_n) begin
            weight_q <= '0;
            col_q    <= '0;
            row_q    <= '0;
        end else if (weight_we) begin
            // only the addressed slot changes, the others keep their weight
            weight_q[weight_slot] <= wbeat.weight;
            col_q[weight_slot]    <= wbeat.col;
            row_q[weight_slot]    <= wbeat.row;
        end
    end

    // the packed arrays flatten straight onto the output vectors.
    // A new weight is visible one cycle after its beat is accepted
    assign weights = weight_q;
    assign w_cols  = col_q;
    assign w_rows  = row_q;

endmodule

`default_nettype wire

// File: hw/cartesian_mult.sv
`timescale 1ns/1ps
`default_nettype none

module cartesian_mult #(
    parameter int frac_bits = 8
) (
    input  wire                                           clk,
    input  wire                                           irst_n,
    input  wire                                           act_fire,
    input  wire  [pe_pkg::LANES*pe_pkg::WORD_W-1:0]       weights,
    input  wire  [pe_pkg::LANES*pe_pkg::WORD_W-1:0]       acts,
    output logic [pe_pkg::PROD_LANES*pe_pkg::WORD_W-1:0]  data_out,
    output logic                                          out_valid
);

    import pe_pkg::*;

    // truncated products of the current beat, lane 4*i+j
    logic [PROD_LANES*WORD_W-1:0] prod_word;

    genvar i;
    genvar j;

    generate
        for (i = 0; i < LANES; i++) begin : g_weight
            for (j = 0; j < LANES; j++) begin : g_act
                logic signed [WORD_W-1:0]   w_val;
                logic signed [WORD_W-1:0]   a_val;
                logic signed [2*WORD_W-1:0] prod;

                assign w_val = weights[i*WORD_W +: WORD_W];
                assign a_val = acts[j*WORD_W +: WORD_W];

                // full signed product, both operands are signed so nothing is lost
                assign prod = w_val * a_val;

                // keep the 16 bits above the fraction, the top bits are dropped
                assign prod_word[(i*LANES+j)*WORD_W +: WORD_W] =
                    prod[frac_bits+WORD_W-1:frac_bits];
            end
        end
    endgenerate

    always_ff @(posedge clk or negedge irst_n) begin
        if (!irst_n) begin
            data_out  <= '0;
            out_valid <= 1'b0;
        end else begin
            // one pulse per accepted activation beat, no stalls downstream
            out_valid <= act_fire;
            // the product word holds its value until the next activation beat
            if (act_fire) begin
                data_out <= prod_word;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/coord_gen.sv
`timescale 1ns/1ps
`default_nettype none

module coord_gen (
    input  wire                                            clk,
    input  wire                                            irst_n,
    input  wire                                            act_fire,
    input  wire  [pe_pkg::LANES*pe_pkg::COORD_W-1:0]       w_cols,
    input  wire  [pe_pkg::LANES*pe_pkg::COORD_W-1:0]       w_rows,
    input  wire  [pe_pkg::LANES*pe_pkg::COORD_W-1:0]       a_cols,
    input  wire  [pe_pkg::LANES*pe_pkg::COORD_W-1:0]       a_rows,
    output logic [pe_pkg::PROD_LANES*pe_pkg::COORD_W-1:0]  out_cols,
    output logic [pe_pkg::PROD_LANES*pe_pkg::COORD_W-1:0]  out_rows
);

    import pe_pkg::*;

    logic [PROD_LANES*COORD_W-1:0] sum_cols;
    logic [PROD_LANES*COORD_W-1:0] sum_rows;

    genvar i;
    genvar j;

    // lane order matches the multiplier, weight slot i and activation lane j at 4*i+j
    generate
        for (i = 0; i < LANES; i++) begin : g_weight
            for (j = 0; j < LANES; j++) begin : g_act
                // 5-bit sums wrap around at 32 by themselves
                assign sum_cols[(i*LANES+j)*COORD_W +: COORD_W] =
                    a_cols[j*COORD_W +: COORD_W] + w_cols[i*COORD_W +: COORD_W];
                assign sum_rows[(i*LANES+j)*COORD_W +: COORD_W] =
                    a_rows[j*COORD_W +: COORD_W] + w_rows[i*COORD_W +: COORD_W];
            end
        end
    endgenerate

    // registered on the same strobe as data_out, so both arrive together
    always_ff @(posedge clk or negedge irst_n) begin
        if (!irst_n) begin
            out_cols <= '0;
            out_rows <= '0;
        end else if (act_fire) begin
            out_cols <= sum_cols;
            out_rows <= sum_rows;
        end
    end

endmodule

`default_nettype wire

// File: hw/pe_top.sv
`timescale 1ns/1ps
`default_nettype none

module pe_top #(
    parameter int frac_bits = 8
) (
    input  wire                                            clk,
    input  wire                                            irst_n,
    input  wire                                            in_valid,
    input  pe_pkg::beat_u                                  beat,
    input  wire  [15:0]                                    pixels,
    output logic                                           out_valid,
    output logic [pe_pkg::PROD_LANES*pe_pkg::WORD_W-1:0]   data_out,
    output logic [pe_pkg::PROD_LANES*pe_pkg::COORD_W-1:0]  out_cols,
    output logic [pe_pkg::PROD_LANES*pe_pkg::COORD_W-1:0]  out_rows
);

    import pe_pkg::*;

    logic                       weight_we;
    logic [1:0]                 weight_slot;
    logic                       act_fire;
    logic [LANES*WORD_W-1:0]    weights;
    logic [LANES*COORD_W-1:0]   w_cols;
    logic [LANES*COORD_W-1:0]   w_rows;

    // both views of the input word, only one is meaningful in a given phase
    weight_beat_t               wbeat;
    act_beat_t                  abeat;

    assign wbeat = beat.w;
    assign abeat = beat.a;

    // the controller alone decides whether a beat is a weight or an activation
    pe_ctrl pe_ctrl_inst (
        .clk         (clk),
        .irst_n      (irst_n),
        .in_valid    (in_valid),
        .pixels      (pixels),
        .weight_we   (weight_we),
        .weight_slot (weight_slot),
        .act_fire    (act_fire)
    );

    weight_bank weight_bank_inst (
        .clk         (clk),
        .irst_n      (irst_n),
        .weight_we   (weight_we),
        .weight_slot (weight_slot),
        .wbeat       (wbeat),
        .weights     (weights),
        .w_cols      (w_cols),
        .w_rows      (w_rows)
    );

    // every stored weight meets the four activations of the current beat
    cartesian_mult #(
        .frac_bits (frac_bits)
    ) cartesian_mult_inst (
        .clk       (clk),
        .irst_n    (irst_n),
        .act_fire  (act_fire),
        .weights   (weights),
        .acts      (abeat.acts),
        .data_out  (data_out),
        .out_valid (out_valid)
    );

    coord_gen coord_gen_inst (
        .clk      (clk),
        .irst_n   (irst_n),
        .act_fire (act_fire),
        .w_cols   (w_cols),
        .w_rows   (w_rows),
        .a_cols   (abeat.cols),
        .a_rows   (abeat.rows),
        .out_cols (out_cols),
        .out_rows (out_rows)
    );

endmodule

`default_nettype wire

// File: test/pe_properties.sv
`timescale 1ns/1ps
`default_nettype none

module pe_properties (
    input  wire            clk,
    input  wire            irst_n,
    input  wire            in_valid,
    input  wire            act_fire,
    input  wire            out_valid,
    input  pe_pkg::phase_t state
);

    import pe_pkg::*;

    // number of assertion failures seen so far
    int unsigned fail_cnt = 0;

    // a product pulse can only follow a cycle spent in the image phase
    out_after_image: assert property (@(posedge clk) disable iff (!irst_n)
        out_valid |-> ($past(state) == load_image))
    else begin
        $error("out_valid high although the previous state was not load_image");
        fail_cnt++;
    end

    // every accepted activation beat gives its pulse on the very next cycle
    fire_then_valid: assert property (@(posedge clk) disable iff (!irst_n)
        act_fire |=> out_valid)
    else begin
        $error("accepted activation beat was not followed by out_valid");
        fail_cnt++;
    end

    // and no pulse appears without such a beat
    valid_needs_fire: assert property (@(posedge clk) disable iff (!irst_n)
        out_valid |-> $past(act_fire))
    else begin
        $error("out_valid high without an activation beat one cycle before");
        fail_cnt++;
    end

    // idle gaps leave the phase where it is
    gap_holds_phase: assert property (@(posedge clk) disable iff (!irst_n)
        !in_valid |=> $stable(state))
    else begin
        $error("phase changed during a cycle without in_valid");
        fail_cnt++;
    end

endmodule

bind pe_top pe_properties pe_properties_inst (
    .clk       (clk),
    .irst_n    (irst_n),
    .in_valid  (in_valid),
    .act_fire  (act_fire),
    .out_valid (out_valid),
    .state     (pe_ctrl_inst.state)
);

`default_nettype wire

// File: test/pe_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pe_tb;

    import pe_pkg::*;

    localparam int frac_bits    = 8;
    localparam int reset_cycles = 10;
    localparam int quiet_cycles = 5;
    localparam int max_gap      = 3;
    localparam int drain_cycles = 8;
    // four images of 36 beats in all, any beat may follow max_gap idle cycles
    localparam int stim_cycles  = reset_cycles + quiet_cycles + 36 * (max_gap + 1)
                                  + 4 * drain_cycles;
    localparam int watchdog_cycles = 2 * stim_cycles + 200;

    logic                          clk;
    logic                          irst_n;
    logic                          in_valid;
    beat_u                         beat;
    logic [15:0]                   pixels;
    logic                          out_valid;
    logic [PROD_LANES*WORD_W-1:0]  data_out;
    logic [PROD_LANES*COORD_W-1:0] out_cols;
    logic [PROD_LANES*COORD_W-1:0] out_rows;

    // model copy of the weight bank, updated as weight beats are sent
    logic [WORD_W-1:0]  model_w [LANES];
    logic [COORD_W-1:0] model_c [LANES];
    logic [COORD_W-1:0] model_r [LANES];

    // one entry per activation beat still waiting for its pulse
    logic [PROD_LANES*WORD_W-1:0]  exp_data [$];
    logic [PROD_LANES*COORD_W-1:0] exp_cols [$];
    logic [PROD_LANES*COORD_W-1:0] exp_rows [$];

    int          err_cnt   = 0;
    int          check_cnt = 0;
    int          pulse_cnt = 0;
    int          test_cnt  = 0;
    int          pix_cur   = 0;
    int unsigned prop_fails;

    pe_top #(
        .frac_bits (frac_bits)
    ) pe_top_inst (
        .clk       (clk),
        .irst_n    (irst_n),
        .in_valid  (in_valid),
        .beat      (beat),
        .pixels    (pixels),
        .out_valid (out_valid),
        .data_out  (data_out),
        .out_cols  (out_cols),
        .out_rows  (out_rows)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [WORD_W-1:0] pick_word(input bit extreme);
        logic [31:0] r;
        r = $urandom();
        if (!extreme) begin
            return r[WORD_W-1:0];
        end
        // corners of the signed range mixed with plain random words
        case (r[18:16])
            3'd0:    return 16'h7fff;
            3'd1:    return 16'h8000;
            3'd2:    return 16'hffff;
            3'd3:    return 16'h8001;
            3'd4:    return 16'h0001;
            default: return r[WORD_W-1:0];
        endcase
    endfunction

    function automatic logic [COORD_W-1:0] pick_coord(input bit extreme);
        logic [31:0] r;
        r = $urandom();
        // near the top of the range, so almost every sum wraps past 31
        if (extreme) begin
            return {3'b111, r[1:0]};
        end
        return r[COORD_W-1:0];
    endfunction

    function automatic int pick_gap(input bit gaps);
        int g;
        g = 0;
        if (gaps) begin
            g = $urandom_range(max_gap, 0);
        end
        return g;
    endfunction

    // junk on the beat bus while in_valid is low must be ignored
    function automatic beat_u random_beat();
        logic [127:0] r;
        beat_u        b;
        r = {$urandom(), $urandom(), $urandom(), $urandom()};
        b = r[$bits(beat_u)-1:0];
        return b;
    endfunction

    // lane 4*i+j is bits 23..8 of weight i times activation j, coordinates add mod 32
    function automatic void push_expected(input act_beat_t ab);
        logic [PROD_LANES*WORD_W-1:0]  d;
        logic [PROD_LANES*COORD_W-1:0] c;
        logic [PROD_LANES*COORD_W-1:0] r;
        logic signed [2*WORD_W-1:0]    p;
        int                            i;
        int                            j;
        int                            k;
        for (i = 0; i < LANES; i++) begin
            for (j = 0; j < LANES; j++) begin
                k = i * LANES + j;
                p = $signed(model_w[i]) * $signed(ab.acts[j]);
                d[k*WORD_W +: WORD_W]   = p[frac_bits+WORD_W-1:frac_bits];
                c[k*COORD_W +: COORD_W] = ab.cols[j] + model_c[i];
                r[k*COORD_W +: COORD_W] = ab.rows[j] + model_r[i];
            end
        end
        exp_data.push_back(d);
        exp_cols.push_back(c);
        exp_rows.push_back(r);
    endfunction

    task automatic drive_beat(input beat_u value, input int gap);
        int n;
        for (n = 0; n < gap; n++) begin
            @(posedge clk);
            in_valid <= 1'b0;
            beat     <= random_beat();
        end
        @(posedge clk);
        in_valid <= 1'b1;
        beat     <= value;
    endtask

    task automatic load_weights(input bit extreme, input bit gaps);
        beat_u b;
        int    i;
        for (i = 0; i < LANES; i++) begin
            b          = '0;
            b.w.weight = pick_word(extreme);
            b.w.col    = pick_coord(extreme);
            b.w.row    = pick_coord(extreme);
            model_w[i] = b.w.weight;
            model_c[i] = b.w.col;
            model_r[i] = b.w.row;
            drive_beat(b, pick_gap(gaps));
            // the image length only counts once the image phase starts
            if (i == 0) begin
                pixels <= pix_cur[15:0];
            end
        end
    endtask

    task automatic send_image(input bit extreme, input bit gaps);
        beat_u b;
        int    n;
        int    j;
        for (n = 0; n < pix_cur; n++) begin
            b = '0;
            for (j = 0; j < LANES; j++) begin
                b.a.acts[j] = pick_word(extreme);
                b.a.cols[j] = pick_coord(extreme);
                b.a.rows[j] = pick_coord(extreme);
            end
            push_expected(b.a);
            drive_beat(b, pick_gap(gaps));
        end
    endtask

    // drop in_valid and wait until every expected pulse has been seen
    task automatic wait_drain();
        int waited;
        waited = 0;
        @(posedge clk);
        in_valid <= 1'b0;
        beat     <= random_beat();
        while (exp_data.size() != 0 && waited < drain_cycles) begin
            @(posedge clk);
            waited++;
        end
        if (exp_data.size() != 0) begin
            err_cnt++;
            $display("%0d expected results never came out of the DUT", exp_data.size());
            exp_data.delete();
            exp_cols.delete();
            exp_rows.delete();
        end
    endtask

    task automatic report_test(input string name, input int err_base, input int check_base);
        test_cnt++;
        $display("%s done: %0d checks, %0d errors", name, check_cnt - check_base,
                 err_cnt - err_base);
    endtask

    task automatic check_quiet(input int cycles);
        int err_base;
        int check_base;
        int n;
        err_base   = err_cnt;
        check_base = check_cnt;
        for (n = 0; n < cycles; n++) begin
            @(negedge clk);
            check_cnt++;
            assert (out_valid == 1'b0) else begin
                err_cnt++;
                $display("Mismatch out_valid: got 0x%h expected 0x0", out_valid);
            end
        end
        report_test("reset_quiet", err_base, check_base);
    endtask

    task automatic run_image(input string name, input int pix, input bit extreme,
                             input bit gaps);
        int err_base;
        int check_base;
        int pulse_base;
        err_base   = err_cnt;
        check_base = check_cnt;
        pulse_base = pulse_cnt;
        pix_cur    = pix;
        load_weights(extreme, gaps);
        send_image(extreme, gaps);
        wait_drain();
        check_cnt++;
        assert (pulse_cnt - pulse_base == pix) else begin
            err_cnt++;
            $display("image of %0d beats gave %0d out_valid pulses", pix,
                     pulse_cnt - pulse_base);
        end
        report_test(name, err_base, check_base);
    endtask

    // outputs are registered on the rising edge, so the falling edge sees them settled
    always @(negedge clk) begin
        logic [PROD_LANES*WORD_W-1:0]  d;
        logic [PROD_LANES*COORD_W-1:0] c;
        logic [PROD_LANES*COORD_W-1:0] r;
        int                            k;
        if (irst_n && out_valid) begin
            pulse_cnt++;
            if (exp_data.size() == 0) begin
                err_cnt++;
                $display("out_valid pulse arrived with no activation beat outstanding");
            end else begin
                d = exp_data.pop_front();
                c = exp_cols.pop_front();
                r = exp_rows.pop_front();
                for (k = 0; k < PROD_LANES; k++) begin
                    check_cnt += 3;
                    assert (data_out[k*WORD_W +: WORD_W] == d[k*WORD_W +: WORD_W]) else begin
                        err_cnt++;
                        $display("Mismatch data_out lane %0d: got 0x%h expected 0x%h", k,
                                 data_out[k*WORD_W +: WORD_W], d[k*WORD_W +: WORD_W]);
                    end
                    assert (out_cols[k*COORD_W +: COORD_W] == c[k*COORD_W +: COORD_W]) else begin
                        err_cnt++;
                        $display("Mismatch out_cols lane %0d: got 0x%h expected 0x%h", k,
                                 out_cols[k*COORD_W +: COORD_W], c[k*COORD_W +: COORD_W]);
                    end
                    assert (out_rows[k*COORD_W +: COORD_W] == r[k*COORD_W +: COORD_W]) else begin
                        err_cnt++;
                        $display("Mismatch out_rows lane %0d: got 0x%h expected 0x%h", k,
                                 out_rows[k*COORD_W +: COORD_W], r[k*COORD_W +: COORD_W]);
                    end
                end
            end
        end
    end

    // a hung run ends here
    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", watchdog_cycles);
        $display("Test failed");
        $finish;
    end

    initial begin
        void'($urandom(32'hfc17));
        irst_n   = 1'b0;
        in_valid = 1'b0;
        beat     = '0;
        pixels   = 16'd0;
        repeat (reset_cycles) @(posedge clk);
        irst_n <= 1'b1;

        check_quiet(quiet_cycles);
        run_image("pixels_3", 3, 1'b0, 1'b0);
        run_image("pixels_7_extreme", 7, 1'b1, 1'b0);
        // new weights after a finished image must show up in the products
        run_image("weight_reload", 7, 1'b0, 1'b0);
        run_image("idle_gaps", 3, 1'b0, 1'b1);

        prop_fails = pe_top_inst.pe_properties_inst.fail_cnt;
        $display("summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
                 test_cnt, check_cnt, err_cnt, prop_fails);
        if (err_cnt == 0 && prop_fails == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
hw/pe_pkg.sv
hw/pe_ctrl.sv
hw/weight_bank.sv
hw/cartesian_mult.sv
hw/coord_gen.sv
hw/pe_top.sv
test/pe_properties.sv
test/pe_tb.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run into a log, then judge the run by the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module pe_tb -f compile.f -o pe_sim \
    || { echo "build failed"; exit 1; }
./obj_dir/pe_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -q "Test failed" sim.log && exit 1
grep -q "Test passed" sim.log || exit 1
exit 0
